// ==== Bender.yml ====
package:
  name: rdm_read_master

sources:
  - rdm_pkg.sv
  - rdm_counter.sv
  - rdm_request_ctrl.sv
  - rdm_ar_channel.sv
  - rdm_data_fifo.sv
  - rdm_read_master.sv
  - target: simulation
    files:
      - tb_read_master_asserts.sv
      - tb_read_master.sv

// ==== build.f ====
rdm_pkg.sv
rdm_counter.sv
rdm_request_ctrl.sv
rdm_ar_channel.sv
rdm_data_fifo.sv
rdm_read_master.sv
tb_read_master_asserts.sv
tb_read_master.sv

// ==== rdm_ar_channel.sv ====
//////////////////////////////////////////////////////////////////////
// AR channel driver with burst stepping and an outstanding cap
// A burst counts as outstanding until its tlast leaves the stream
// Base address is taken as already aligned to BURST_BYTES
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rdm_ar_channel import rdm_pkg::*; (
  input  logic                       aclk,
  input  logic                       areset,
  input  logic                       burst_start,
  input  logic [ADDR_WIDTH-1:0]      base_addr,
  input  logic [BURST_CNT_WIDTH-1:0] num_bursts,
  input  logic [7:0]                 final_burst_len,
  input  logic                       burst_drained,
  input  logic                       m_axi_arready,
  output logic                       m_axi_arvalid,
  output logic [ADDR_WIDTH-1:0]      m_axi_araddr,
  output logic [7:0]                 m_axi_arlen
);

  logic arxfer;
  logic busy;
  logic ar_final_burst;
  logic ar_done;
  logic stall;

  // Address handshake
  assign arxfer  = m_axi_arvalid && m_axi_arready;
  assign ar_done = arxfer && ar_final_burst;

  //////////////////////////////////////////////////////////////////////
  // Issue control
  //////////////////////////////////////////////////////////////////////

  // Busy from pass start until the final burst is accepted
  always_ff @(posedge aclk) begin
    if (areset) begin
      busy <= 1'b0;
    end else if (burst_start) begin
      busy <= 1'b1;
    end else if (ar_done) begin
      busy <= 1'b0;
    end
  end

  // Raise only from low, so a new request waits a cycle after a handshake
  // Held high until arready, whatever the vacancy does meanwhile
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axi_arvalid <= 1'b0;
    end else if (!m_axi_arvalid) begin
      m_axi_arvalid <= busy && !stall;
    end else if (m_axi_arready) begin
      m_axi_arvalid <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Address and length
  //////////////////////////////////////////////////////////////////////

  // Step one full burst per accepted request
  always_ff @(posedge aclk) begin
    if (burst_start) begin
      m_axi_araddr <= base_addr;
    end else if (arxfer) begin
      m_axi_araddr <= m_axi_araddr + ADDR_WIDTH'(BURST_BYTES);
    end
  end

  // Full length except on the final burst of the pass
  assign m_axi_arlen = ar_final_burst ? final_burst_len : 8'(BURST_BEATS - 1);

  // AR bursts left to issue, zero on the final one
  rdm_counter #(
    .WIDTH (BURST_CNT_WIDTH),
    .INIT  ('0)
  ) u_ar_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (burst_start),
    .incr       (1'b0),
    .decr       (arxfer),
    .load_value (num_bursts),
    .count      (),
    .is_zero    (ar_final_burst)
  );

  // Free burst slots in the FIFO
  // Persists across passes and requests since the FIFO may still hold data
  rdm_counter #(
    .WIDTH (OUTSTANDING_WIDTH),
    .INIT  (OUTSTANDING_WIDTH'(MAX_OUTSTANDING))
  ) u_vacancy_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (burst_drained),
    .decr       (arxfer),
    .load_value ('0),
    .count      (),
    .is_zero    (stall)
  );

endmodule

// ==== rdm_counter.sv ====
//////////////////////////////////////////////////////////////////////
// Loadable up/down counter with a registered zero flag
// Load wins over incr and decr; incr and decr together hold the count
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rdm_counter import rdm_pkg::*; #(
  parameter int               WIDTH = BURST_CNT_WIDTH,
  parameter logic [WIDTH-1:0] INIT  = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic             incr,
  input  logic             decr,
  input  logic [WIDTH-1:0] load_value,
  output logic [WIDTH-1:0] count,
  output logic             is_zero
);

  // Zero flag follows the next count value so both change on one edge
  always_ff @(posedge aclk) begin
    if (areset) begin
      count   <= INIT;
      is_zero <= (INIT == '0);
    end else if (load) begin
      count   <= load_value;
      is_zero <= (load_value == '0);
    end else if (incr && !decr) begin
      count   <= count + 1'b1;
      // Wraps to zero only from all ones
      is_zero <= (count == {WIDTH{1'b1}});
    end else if (decr && !incr) begin
      count   <= count - 1'b1;
      is_zero <= (count == WIDTH'(1));
    end
  end

endmodule

// ==== rdm_data_fifo.sv ====
//////////////////////////////////////////////////////////////////////
// First-word-fall-through FIFO from R to the stream output
// No full flag; the AR outstanding cap keeps writes within depth
// Head word is read combinationally from the memory
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rdm_data_fifo import rdm_pkg::*; (
  input  logic                  aclk,
  input  logic                  areset,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  wr_last,
  input  logic                  m_axis_tready,
  output logic                  m_axis_tvalid,
  output logic [DATA_WIDTH-1:0] m_axis_tdata,
  output logic                  m_axis_tlast,
  output logic                  burst_drained
);

  // Data with its last flag on top
  logic [DATA_WIDTH:0] mem [FIFO_DEPTH];

  // One extra bit tells full from empty
  logic [FIFO_ADDR_WIDTH:0]   wr_ptr;
  logic [FIFO_ADDR_WIDTH:0]   rd_ptr;
  logic [FIFO_ADDR_WIDTH-1:0] wr_idx;
  logic [FIFO_ADDR_WIDTH-1:0] rd_idx;
  logic                       rd_en;

  assign wr_idx = wr_ptr[FIFO_ADDR_WIDTH-1:0];
  assign rd_idx = rd_ptr[FIFO_ADDR_WIDTH-1:0];

  //////////////////////////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_idx] <= {wr_last, wr_data};
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////////////////////////

  // Valid whenever a word sits at the head
  assign m_axis_tvalid = (wr_ptr != rd_ptr);
  assign {m_axis_tlast, m_axis_tdata} = mem[rd_idx];

  // Word handed over on the stream
  assign rd_en = m_axis_tvalid && m_axis_tready;

  always_ff @(posedge aclk) begin
    if (areset) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // One burst slot freed per tlast word leaving
  assign burst_drained = rd_en && m_axis_tlast;

endmodule

// ==== rdm_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Widths, limits and state encoding shared by the read master blocks
// Data width must be a power of two bytes; bursts never exceed 16 beats
// FIFO depth is sized so every issued burst fits without back-pressure
//////////////////////////////////////////////////////////////////////

package rdm_pkg;

  // Bus widths
  localparam int ADDR_WIDTH      = 32;
  localparam int DATA_WIDTH      = 32;
  localparam int XFER_SIZE_WIDTH = 16;

  // Bytes per data word and its log
  localparam int DW_BYTES     = DATA_WIDTH / 8;
  localparam int LOG_DW_BYTES = $clog2(DW_BYTES);

  // Project burst limit, far below the AXI maximum of 256
  localparam int BURST_BEATS     = 16;
  localparam int LOG_BURST_BEATS = $clog2(BURST_BEATS);
  // Start addresses are aligned down to this
  localparam int BURST_BYTES     = BURST_BEATS * DW_BYTES;

  // Bursts in flight between AR issue and stream drain
  localparam int MAX_OUTSTANDING   = 4;
  localparam int OUTSTANDING_WIDTH = $clog2(MAX_OUTSTANDING + 1);

  // Word count minus one, and the number of full bursts after the first
  localparam int TOTAL_LEN_WIDTH = XFER_SIZE_WIDTH - LOG_DW_BYTES;
  localparam int BURST_CNT_WIDTH = TOTAL_LEN_WIDTH - LOG_BURST_BEATS;

  // Room for every outstanding burst
  localparam int FIFO_DEPTH      = BURST_BEATS * MAX_OUTSTANDING;
  localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH);

  // Replays of the whole read sequence per request
  localparam int NUM_PASSES     = 4;
  localparam int PASS_CNT_WIDTH = $clog2(NUM_PASSES);

  // Request controller states
  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    RUN,
    FINISH
  } pass_state_t;

endpackage

// ==== rdm_read_master.sv ====
//////////////////////////////////////////////////////////////////////
// AXI4 read master streaming its data out, top level
// rready is tied high; the outstanding cap guarantees FIFO room
// Start is legal only when idle or after done
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rdm_read_master import rdm_pkg::*; (
  input  logic                       aclk,
  input  logic                       areset,

  // Control
  input  logic                       ctrl_start,
  input  logic [ADDR_WIDTH-1:0]      ctrl_addr_offset,
  input  logic [XFER_SIZE_WIDTH-1:0] ctrl_xfer_size_in_bytes,
  output logic                       ctrl_done,

  // AXI4 read address channel
  output logic                       m_axi_arvalid,
  input  logic                       m_axi_arready,
  output logic [ADDR_WIDTH-1:0]      m_axi_araddr,
  output logic [7:0]                 m_axi_arlen,

  // AXI4 read data channel
  input  logic                       m_axi_rvalid,
  output logic                       m_axi_rready,
  input  logic [DATA_WIDTH-1:0]      m_axi_rdata,
  input  logic                       m_axi_rlast,

  // AXI4-Stream output
  output logic                       m_axis_tvalid,
  input  logic                       m_axis_tready,
  output logic [DATA_WIDTH-1:0]      m_axis_tdata,
  output logic                       m_axis_tlast
);

  // Per-pass burst plan from the controller
  logic                       burst_start;
  logic [ADDR_WIDTH-1:0]      base_addr;
  logic [BURST_CNT_WIDTH-1:0] num_bursts;
  logic [7:0]                 final_burst_len;
  // Burst slot freed on the stream side
  logic                       burst_drained;

  // Always ready, every beat is written to the FIFO
  assign m_axi_rready = 1'b1;

  rdm_request_ctrl u_request_ctrl (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .rvalid                  (m_axi_rvalid),
    .rlast                   (m_axi_rlast),
    .burst_start             (burst_start),
    .base_addr               (base_addr),
    .num_bursts              (num_bursts),
    .final_burst_len         (final_burst_len),
    .ctrl_done               (ctrl_done)
  );

  rdm_ar_channel u_ar_channel (
    .aclk            (aclk),
    .areset          (areset),
    .burst_start     (burst_start),
    .base_addr       (base_addr),
    .num_bursts      (num_bursts),
    .final_burst_len (final_burst_len),
    .burst_drained   (burst_drained),
    .m_axi_arready   (m_axi_arready),
    .m_axi_arvalid   (m_axi_arvalid),
    .m_axi_araddr    (m_axi_araddr),
    .m_axi_arlen     (m_axi_arlen)
  );

  rdm_data_fifo u_data_fifo (
    .aclk          (aclk),
    .areset        (areset),
    .wr_en         (m_axi_rvalid),
    .wr_data       (m_axi_rdata),
    .wr_last       (m_axi_rlast),
    .m_axis_tready (m_axis_tready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .burst_drained (burst_drained)
  );

endmodule

// ==== rdm_request_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// Request capture, burst split and pass loop
// Transfer size must be nonzero; start is ignored until the FSM is idle
// Done marks the last R beat, not the end of the stream output
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rdm_request_ctrl import rdm_pkg::*; (
  input  logic                       aclk,
  input  logic                       areset,
  input  logic                       ctrl_start,
  input  logic [ADDR_WIDTH-1:0]      ctrl_addr_offset,
  input  logic [XFER_SIZE_WIDTH-1:0] ctrl_xfer_size_in_bytes,
  input  logic                       rvalid,
  input  logic                       rlast,
  output logic                       burst_start,
  output logic [ADDR_WIDTH-1:0]      base_addr,
  output logic [BURST_CNT_WIDTH-1:0] num_bursts,
  output logic [7:0]                 final_burst_len,
  output logic                       ctrl_done
);

  pass_state_t               state;
  logic [PASS_CNT_WIDTH-1:0] pass_cnt;
  logic [TOTAL_LEN_WIDTH-1:0] total_len_r;
  logic                      r_burst_end;
  logic                      r_final_burst;
  logic                      pass_end;

  //////////////////////////////////////////////////////////////////////
  // Pass FSM
  //////////////////////////////////////////////////////////////////////

  // End of a burst on R, and end of the last burst of the pass
  assign r_burst_end = rvalid && rlast;
  assign pass_end    = (state == RUN) && r_burst_end && r_final_burst;

  always_ff @(posedge aclk) begin
    if (areset) begin
      state       <= IDLE;
      pass_cnt    <= '0;
      burst_start <= 1'b0;
    end else begin
      burst_start <= 1'b0;
      case (state)
        IDLE: begin
          if (ctrl_start) begin
            state    <= SETUP;
            pass_cnt <= '0;
          end
        end
        // Burst split registered here, AR side starts one cycle later
        SETUP: begin
          state       <= RUN;
          burst_start <= 1'b1;
        end
        RUN: begin
          if (pass_end) begin
            if (pass_cnt == PASS_CNT_WIDTH'(NUM_PASSES - 1)) begin
              state <= FINISH;
            end else begin
              // Replay the same sequence
              state    <= SETUP;
              pass_cnt <= pass_cnt + 1'b1;
            end
          end
        end
        // One cycle of done, then idle
        FINISH: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  assign ctrl_done = (state == FINISH);

  //////////////////////////////////////////////////////////////////////
  // Request capture and burst split
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if ((state == IDLE) && ctrl_start) begin
      // Align down to a burst boundary
      base_addr <= ctrl_addr_offset & ~ADDR_WIDTH'(BURST_BYTES - 1);
      // Round up to whole words, kept as count minus one
      if (ctrl_xfer_size_in_bytes[LOG_DW_BYTES-1:0] != '0) begin
        total_len_r <= ctrl_xfer_size_in_bytes[LOG_DW_BYTES +: TOTAL_LEN_WIDTH];
      end else begin
        total_len_r <= ctrl_xfer_size_in_bytes[LOG_DW_BYTES +: TOTAL_LEN_WIDTH] - 1'b1;
      end
    end
    if (state == SETUP) begin
      // Upper bits count the full bursts after the first
      num_bursts      <= total_len_r[LOG_BURST_BEATS +: BURST_CNT_WIDTH];
      // Low bits give the arlen of the last burst
      final_burst_len <= 8'(total_len_r[LOG_BURST_BEATS-1:0]);
    end
  end

  // R bursts still to arrive in this pass, zero on the final one
  rdm_counter #(
    .WIDTH (BURST_CNT_WIDTH),
    .INIT  ('0)
  ) u_r_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (burst_start),
    .incr       (1'b0),
    .decr       (r_burst_end),
    .load_value (num_bursts),
    .count      (),
    .is_zero    (r_final_burst)
  );

endmodule

// ==== tb_read_master.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the read master with an AXI read slave model
// Slave returns each beat's own byte address as its data
// Each row waits for ctrl_done and a drained stream before the next
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_read_master import rdm_pkg::*; ();

  localparam int NUM_ROWS = 6;
  localparam int TIMEOUT  = 20000;

  logic                       aclk;
  logic                       areset;
  logic                       ctrl_start;
  logic [ADDR_WIDTH-1:0]      ctrl_addr_offset;
  logic [XFER_SIZE_WIDTH-1:0] ctrl_xfer_size_in_bytes;
  logic                       ctrl_done;
  logic                       m_axi_arvalid;
  logic                       m_axi_arready = 1'b0;
  logic [ADDR_WIDTH-1:0]      m_axi_araddr;
  logic [7:0]                 m_axi_arlen;
  logic                       m_axi_rvalid  = 1'b0;
  logic                       m_axi_rready;
  logic [DATA_WIDTH-1:0]      m_axi_rdata   = '0;
  logic                       m_axi_rlast   = 1'b0;
  logic                       m_axis_tvalid;
  logic                       m_axis_tready = 1'b0;
  logic [DATA_WIDTH-1:0]      m_axis_tdata;
  logic                       m_axis_tlast;

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////

  // Start address, size in bytes, tready density in eighths
  int unsigned row_addr   [NUM_ROWS] = '{'h100, 'h1234, 'h1234, 'h2010, 'h3ffc, 'h4000_0038};
  int unsigned row_size   [NUM_ROWS] = '{20, 300, 300, 256, 4, 1027};
  int unsigned row_ready  [NUM_ROWS] = '{8, 8, 3, 1, 2, 5};
  // Expected aligned base, word count and bursts per pass
  int unsigned row_base   [NUM_ROWS] = '{'h100, 'h1200, 'h1200, 'h2000, 'h3fc0, 'h4000_0000};
  int unsigned row_words  [NUM_ROWS] = '{5, 75, 75, 64, 1, 257};
  int unsigned row_bursts [NUM_ROWS] = '{1, 5, 5, 4, 1, 17};

  // Expected AR requests and stream words with the oldest first
  logic [ADDR_WIDTH-1:0] exp_araddr_q [$];
  logic [7:0]            exp_arlen_q  [$];
  logic [DATA_WIDTH-1:0] exp_data_q   [$];
  bit                    exp_last_q   [$];
  // Bursts accepted by the slave and not yet fully returned
  logic [ADDR_WIDTH-1:0] ar_addr_q    [$];
  logic [7:0]            ar_len_q     [$];
  logic [7:0]            beat_idx       = '0;
  int unsigned           ar_count       = 0;
  int unsigned           drained_count  = 0;
  int unsigned           rlast_count    = 0;
  int unsigned           rlast_target   = 0;
  int unsigned           done_count     = 0;
  int unsigned           tready_density = 8;
  logic [31:0]           lfsr           = 32'h9289d407;

  rdm_read_master rdm_read_master_inst (.*);

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic int unsigned lfsr_bits(input int n);
    int unsigned v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | lfsr_bit();
    end
    return v;
  endfunction

  function automatic string mismatch_line(input string name, input logic [31:0] got,
                                          input logic [31:0] expected);
    return $sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // Full AR and stream sequence of one row over all passes
  task automatic load_expected(input int r);
    int unsigned last_len;
    last_len     = (row_words[r] - 1) % BURST_BEATS;
    rlast_count  = 0;
    done_count   = 0;
    rlast_target = row_bursts[r] * NUM_PASSES;
    for (int p = 0; p < NUM_PASSES; p++) begin
      for (int b = 0; b < row_bursts[r]; b++) begin
        exp_araddr_q.push_back(32'(row_base[r] + b * BURST_BYTES));
        exp_arlen_q.push_back((b == row_bursts[r] - 1) ? 8'(last_len) : 8'(BURST_BEATS - 1));
      end
      // tlast at the end of every full burst and on the final word
      for (int i = 0; i < row_words[r]; i++) begin
        exp_data_q.push_back(32'(row_base[r] + i * DW_BYTES));
        exp_last_q.push_back((i % BURST_BEATS == BURST_BEATS - 1) || (i == row_words[r] - 1));
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Slave model and stream sink
  //////////////////////////////////////////////////////////////////////

  // Inputs change on the falling edge only
  always @(negedge aclk) begin
    m_axis_tready = (lfsr_bits(3) < tready_density);
    m_axi_arready = lfsr_bit() && (ar_addr_q.size() < MAX_OUTSTANDING);
    // Idle cycle between beats about one time in four
    m_axi_rvalid  = (lfsr_bits(2) != 0) && (ar_addr_q.size() != 0);
    if (m_axi_rvalid) begin
      m_axi_rdata = ar_addr_q[0] + DW_BYTES * beat_idx;
      m_axi_rlast = (beat_idx == ar_len_q[0]);
    end else begin
      m_axi_rdata = '0;
      m_axi_rlast = 1'b0;
    end
  end

  // Handshakes as seen at the rising edge
  always @(posedge aclk) begin
    if (!areset) begin
      assert (rdm_read_master_inst.u_protocol_checks.error_count == 0)
        else report_failure("Handshake rule violated on the AR channel or the stream");
      if (m_axi_arvalid && m_axi_arready) begin
        assert (exp_araddr_q.size() != 0)
          else report_failure("AR burst issued beyond the expected count");
        assert (m_axi_araddr == exp_araddr_q[0])
          else report_failure(mismatch_line("m_axi_araddr", m_axi_araddr, exp_araddr_q[0]));
        assert (m_axi_arlen == exp_arlen_q[0])
          else report_failure(mismatch_line("m_axi_arlen", m_axi_arlen, exp_arlen_q[0]));
        ar_addr_q.push_back(exp_araddr_q.pop_front());
        ar_len_q.push_back(exp_arlen_q.pop_front());
        ar_count++;
      end
      // rready is tied high so every valid beat is taken
      assert (m_axi_rready)
        else report_failure(mismatch_line("m_axi_rready", 32'(m_axi_rready), 32'd1));
      if (m_axi_rvalid) begin
        if (m_axi_rlast) begin
          void'(ar_addr_q.pop_front());
          void'(ar_len_q.pop_front());
          beat_idx = '0;
          rlast_count++;
        end else begin
          beat_idx++;
        end
      end
      if (m_axis_tvalid && m_axis_tready) begin
        assert (exp_data_q.size() != 0)
          else report_failure("Stream word beyond the expected count");
        assert (m_axis_tdata == exp_data_q[0])
          else report_failure(mismatch_line("m_axis_tdata", m_axis_tdata, exp_data_q[0]));
        assert (m_axis_tlast == exp_last_q[0])
          else report_failure(mismatch_line("m_axis_tlast", 32'(m_axis_tlast),
                                            32'(exp_last_q[0])));
        void'(exp_data_q.pop_front());
        void'(exp_last_q.pop_front());
        if (m_axis_tlast) begin
          drained_count++;
        end
      end
      assert (ar_count - drained_count <= MAX_OUTSTANDING)
        else report_failure("More bursts in flight than MAX_OUTSTANDING");
      if (ctrl_done) begin
        assert (rlast_count == rlast_target)
          else report_failure("ctrl_done came before the last rlast of the last pass");
        done_count++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int wait_cycles;
    areset                  = 1'b1;
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    repeat (3) @(negedge aclk);
    areset = 1'b0;
    // Quiet outputs before the first start
    repeat (4) begin
      @(negedge aclk);
      assert (!m_axi_arvalid && !m_axis_tvalid && !ctrl_done)
        else report_failure("AR, stream or done went active with no start");
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      load_expected(r);
      tready_density          <= row_ready[r];
      ctrl_addr_offset        = ADDR_WIDTH'(row_addr[r]);
      ctrl_xfer_size_in_bytes = XFER_SIZE_WIDTH'(row_size[r]);
      ctrl_start              = 1'b1;
      @(negedge aclk);
      ctrl_start  = 1'b0;
      wait_cycles = 0;
      while (done_count == 0 && wait_cycles < TIMEOUT) begin
        @(negedge aclk);
        wait_cycles++;
      end
      assert (done_count != 0)
        else report_failure($sformatf("Timeout waiting for ctrl_done on row %0d", r));
      // Stream may still hold words after done
      wait_cycles = 0;
      while (exp_data_q.size() != 0 && wait_cycles < TIMEOUT) begin
        @(negedge aclk);
        wait_cycles++;
      end
      assert (exp_data_q.size() == 0)
        else report_failure($sformatf("Timeout waiting for stream words on row %0d", r));
      // Window for a stray second done pulse
      repeat (8) @(negedge aclk);
      assert (done_count == 1)
        else report_failure($sformatf("ctrl_done pulsed %0d times on row %0d", done_count, r));
      assert (exp_araddr_q.size() == 0)
        else report_failure($sformatf("Fewer AR bursts than expected on row %0d", r));
    end
    if (rdm_read_master_inst.u_protocol_checks.error_count == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      report_failure("Handshake rule violated on the AR channel or the stream");
    end
  end

endmodule

// ==== tb_read_master_asserts.sv ====
//////////////////////////////////////////////////////////////////////
// Handshake rules on AR and stream outputs, bound into the top level
// Checked only outside reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_read_master_asserts import rdm_pkg::*; (
  input logic                  aclk,
  input logic                  areset,
  input logic                  m_axi_arvalid,
  input logic                  m_axi_arready,
  input logic [ADDR_WIDTH-1:0] m_axi_araddr,
  input logic [7:0]            m_axi_arlen,
  input logic                  m_axis_tvalid,
  input logic                  m_axis_tready,
  input logic [DATA_WIDTH-1:0] m_axis_tdata,
  input logic                  m_axis_tlast
);

  // Failed rule count polled by the testbench
  int unsigned error_count = 0;

  // AR request held with its address and length until accepted
  ar_hold: assert property (@(posedge aclk) disable iff (areset)
    m_axi_arvalid && !m_axi_arready |=>
      m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen))
    else begin
      $error("arvalid dropped or araddr/arlen changed before arready");
      error_count++;
    end

  // Stream word held until taken
  stream_hold: assert property (@(posedge aclk) disable iff (areset)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
    else begin
      $error("tvalid dropped or tdata/tlast changed before tready");
      error_count++;
    end

endmodule

bind rdm_read_master tb_read_master_asserts u_protocol_checks (.*);
